// File: Bender.yml
package:
  name: cache_bank

sources:
  - hw/cache_bank_pkg.sv
  - hw/bank_fifo.sv
  - hw/miss_reserve.sv
  - hw/tag_data_store.sv
  - hw/bank_pipeline.sv
  - hw/cache_bank.sv
  - target: test
    files:
      - verification/cache_bank_tb.sv

// File: hw/bank_fifo.sv
`timescale 1ns/1ps

module bank_fifo #(
	parameter int width = 32,
	parameter int depth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic [width-1:0] in_data,
	input  logic pop,
	output logic [width-1:0] out_data,
	output logic empty,
	output logic full
);
	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign empty = count == 0;
	assign full = count == depth;
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

// File: hw/bank_pipeline.sv
`timescale 1ns/1ps

module bank_pipeline (
	input  logic clk,
	input  logic reset,

	input  logic reqq_empty,
	input  cache_bank_pkg::req_op_e reqq_op,
	input  logic [cache_bank_pkg::addr_w-1:0] reqq_addr,
	input  logic [cache_bank_pkg::word_w-1:0] reqq_wdata,
	input  logic [cache_bank_pkg::id_w-1:0] reqq_id,
	output logic reqq_pop,

	input  logic dfpq_empty,
	input  logic [cache_bank_pkg::addr_w-1:0] dfpq_addr,
	input  logic [cache_bank_pkg::line_w-1:0] dfpq_line,
	output logic dfpq_pop,

	input  logic mrvq_head_ready,
	input  cache_bank_pkg::req_op_e mrvq_head_op,
	input  logic [cache_bank_pkg::addr_w-1:0] mrvq_head_addr,
	input  logic [cache_bank_pkg::word_w-1:0] mrvq_head_wdata,
	input  logic [cache_bank_pkg::id_w-1:0] mrvq_head_id,
	input  logic mrvq_almost_full,
	input  logic mrvq_full,
	output logic mrvq_pop,
	output logic mrvq_add,
	output cache_bank_pkg::req_op_e miss_op,
	output logic [cache_bank_pkg::addr_w-1:0] miss_addr,
	output logic [cache_bank_pkg::word_w-1:0] miss_wdata,
	output logic [cache_bank_pkg::id_w-1:0] miss_id,
	output logic fill_seen,
	output logic [cache_bank_pkg::addr_w-1:0] fill_line_addr,

	output logic [cache_bank_pkg::index_w-1:0] rd_index,
	input  logic rd_valid,
	input  logic rd_dirty,
	input  logic [cache_bank_pkg::tag_w-1:0] rd_tag,
	input  logic [cache_bank_pkg::line_w-1:0] rd_line,
	output logic wr_en,
	output logic [cache_bank_pkg::index_w-1:0] wr_index,
	output logic [cache_bank_pkg::tag_w-1:0] wr_tag,
	output logic [cache_bank_pkg::line_w-1:0] wr_line,
	output logic wr_dirty,

	input  logic cwbq_full,
	output logic cwbq_push,
	output logic [cache_bank_pkg::id_w-1:0] cwbq_id,
	output logic [cache_bank_pkg::addr_w-1:0] cwbq_addr,
	output logic [cache_bank_pkg::word_w-1:0] cwbq_data,

	input  logic dwbq_full,
	output logic dwbq_push,
	output logic [cache_bank_pkg::addr_w-1:0] dwbq_addr,
	output logic [cache_bank_pkg::line_w-1:0] dwbq_line,

	input  logic dram_fill_req_full,
	output logic dram_fill_req,
	output logic [cache_bank_pkg::addr_w-1:0] dram_fill_req_addr
);
	import cache_bank_pkg::*;

	logic stall;
	logic fill_in_pipe;

	pipe_src_e src_s0;
	req_op_e s0_op;
	logic [addr_w-1:0] s0_addr;
	logic [word_w-1:0] s0_wdata;
	logic [id_w-1:0] s0_id;

	pipe_src_e s1_src;
	req_op_e s1_op;
	logic [addr_w-1:0] s1_addr;
	logic [word_w-1:0] s1_wdata;
	logic [id_w-1:0] s1_id;
	logic [line_w-1:0] s1_line;
	logic [index_w-1:0] s1_index;
	logic [tag_w-1:0] s1_tag;
	logic [offset_w-1:0] s1_offset;
	logic s1_is_req;
	logic s1_is_fill;
	logic s1_hit;
	logic [word_w-1:0] s1_rword;
	logic [line_w-1:0] s1_merged;

	pipe_src_e s2_src;
	req_op_e s2_op;
	logic [addr_w-1:0] s2_addr;
	logic [word_w-1:0] s2_word;
	logic [id_w-1:0] s2_id;
	logic s2_miss;
	logic s2_victim;
	logic [addr_w-1:0] s2_victim_addr;
	logic [line_w-1:0] s2_victim_line;
	logic s2_is_req;
	logic s2_is_fill;
	logic s2_hit;
	logic s2_missed;
	logic s2_evict;

	// Stage 0, fixed priority replay > fill > core
	assign fill_in_pipe = (s1_src == src_fill) || (s2_src == src_fill);

	always_comb begin
		if (mrvq_head_ready) begin
			src_s0 = src_replay;
		end else if (!dfpq_empty) begin
			src_s0 = src_fill;
		end else if (!reqq_empty && !mrvq_almost_full && !fill_in_pipe) begin
			src_s0 = src_core;
		end else begin
			src_s0 = src_none;
		end
	end

	assign mrvq_pop = (src_s0 == src_replay) && !stall;
	assign dfpq_pop = (src_s0 == src_fill) && !stall;
	assign reqq_pop = (src_s0 == src_core) && !stall;

	always_comb begin
		s0_op = op_read;
		s0_addr = '0;
		s0_wdata = '0;
		s0_id = '0;
		case (src_s0)
			src_replay: begin
				s0_op = mrvq_head_op;
				s0_addr = mrvq_head_addr;
				s0_wdata = mrvq_head_wdata;
				s0_id = mrvq_head_id;
			end
			src_fill: s0_addr = dfpq_addr;
			src_core: begin
				s0_op = reqq_op;
				s0_addr = reqq_addr;
				s0_wdata = reqq_wdata;
				s0_id = reqq_id;
			end
			default: ;
		endcase
	end

	// Stage 1, tag compare and store update
	assign s1_index = s1_addr[line_lsb +: index_w];
	assign s1_tag = s1_addr[tag_lsb +: tag_w];
	assign s1_offset = s1_addr[byte_w +: offset_w];
	assign s1_is_req = (s1_src == src_replay) || (s1_src == src_core);
	assign s1_is_fill = s1_src == src_fill;
	assign s1_hit = rd_valid && (rd_tag == s1_tag);
	assign s1_rword = rd_line[s1_offset*word_w +: word_w];
	assign rd_index = s1_index;

	always_comb begin
		s1_merged = rd_line;
		s1_merged[s1_offset*word_w +: word_w] = s1_wdata;
	end

	// Fill of a line already holding this tag is dropped
	assign wr_en = !stall && ((s1_is_req && s1_hit && s1_op == op_write) ||
		(s1_is_fill && !s1_hit));
	assign wr_index = s1_index;
	assign wr_tag = s1_tag;
	assign wr_line = s1_is_fill ? s1_line : s1_merged;
	assign wr_dirty = s1_is_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_src <= src_none;
			s2_src <= src_none;
		end else if (!stall) begin
			s1_src <= src_s0;
			s2_src <= s1_src;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s1_op <= s0_op;
			s1_addr <= s0_addr;
			s1_wdata <= s0_wdata;
			s1_id <= s0_id;
			s1_line <= dfpq_line;
			s2_op <= s1_op;
			s2_addr <= s1_addr;
			s2_word <= (s1_op == op_write) ? s1_wdata : s1_rword;
			s2_id <= s1_id;
			s2_miss <= !s1_hit;
			s2_victim <= s1_is_fill && !s1_hit && rd_valid && rd_dirty;
			s2_victim_addr <= {rd_tag, s1_index, {line_lsb{1'b0}}};
			s2_victim_line <= rd_line;
		end
	end

	// Stage 2 routing
	assign s2_is_req = (s2_src == src_replay) || (s2_src == src_core);
	assign s2_is_fill = s2_src == src_fill;
	assign s2_hit = s2_is_req && !s2_miss;
	assign s2_missed = s2_is_req && s2_miss;
	assign s2_evict = s2_is_fill && s2_victim;

	// Holds all three stages together
	assign stall = (s2_hit && cwbq_full) ||
		(s2_missed && (mrvq_full || dram_fill_req_full)) ||
		(s2_evict && dwbq_full);

	assign cwbq_push = s2_hit && !stall;
	assign cwbq_id = s2_id;
	assign cwbq_addr = s2_addr;
	assign cwbq_data = s2_word;

	assign mrvq_add = s2_missed && !stall;
	assign miss_op = s2_op;
	assign miss_addr = s2_addr;
	assign miss_wdata = s2_word;
	assign miss_id = s2_id;

	assign dram_fill_req = s2_missed && !stall;
	assign dram_fill_req_addr = {s2_addr[addr_w-1:line_lsb], {line_lsb{1'b0}}};

	assign fill_seen = s2_is_fill && !stall;
	assign fill_line_addr = {s2_addr[addr_w-1:line_lsb], {line_lsb{1'b0}}};

	assign dwbq_push = s2_evict && !stall;
	assign dwbq_addr = s2_victim_addr;
	assign dwbq_line = s2_victim_line;

endmodule

// File: hw/cache_bank.sv
`timescale 1ns/1ps

module cache_bank (
	input  logic clk,
	input  logic reset,

	input  logic req_valid,
	input  cache_bank_pkg::req_op_e req_op,
	input  logic [cache_bank_pkg::addr_w-1:0] req_addr,
	input  logic [cache_bank_pkg::word_w-1:0] req_wdata,
	input  logic [cache_bank_pkg::id_w-1:0] req_id,
	output logic req_full,

	output logic rsp_valid,
	output logic [cache_bank_pkg::id_w-1:0] rsp_id,
	output logic [cache_bank_pkg::addr_w-1:0] rsp_addr,
	output logic [cache_bank_pkg::word_w-1:0] rsp_data,
	input  logic rsp_pop,

	output logic dram_fill_req,
	output logic [cache_bank_pkg::addr_w-1:0] dram_fill_req_addr,
	input  logic dram_fill_req_full,

	input  logic dram_fill_rsp,
	input  logic [cache_bank_pkg::addr_w-1:0] dram_fill_addr,
	input  logic [cache_bank_pkg::line_w-1:0] dram_fill_data,
	output logic dram_fill_accept,

	output logic dram_wb_req,
	output logic [cache_bank_pkg::addr_w-1:0] dram_wb_addr,
	output logic [cache_bank_pkg::line_w-1:0] dram_wb_data,
	input  logic dram_wb_pop
);
	import cache_bank_pkg::*;

	logic reqq_empty;
	logic reqq_pop;
	logic reqq_op_bit;
	req_op_e reqq_op;
	logic [addr_w-1:0] reqq_addr;
	logic [word_w-1:0] reqq_wdata;
	logic [id_w-1:0] reqq_id;

	logic dfpq_empty;
	logic dfpq_full;
	logic dfpq_pop;
	logic [addr_w-1:0] dfpq_addr;
	logic [line_w-1:0] dfpq_line;

	logic cwbq_empty;
	logic cwbq_full;
	logic cwbq_push;
	logic [id_w-1:0] cwbq_id;
	logic [addr_w-1:0] cwbq_addr;
	logic [word_w-1:0] cwbq_data;

	logic dwbq_empty;
	logic dwbq_full;
	logic dwbq_push;
	logic [addr_w-1:0] dwbq_addr;
	logic [line_w-1:0] dwbq_line;

	logic mrvq_head_ready;
	req_op_e mrvq_head_op;
	logic [addr_w-1:0] mrvq_head_addr;
	logic [word_w-1:0] mrvq_head_wdata;
	logic [id_w-1:0] mrvq_head_id;
	logic mrvq_almost_full;
	logic mrvq_full;
	logic mrvq_pop;
	logic mrvq_add;
	req_op_e miss_op;
	logic [addr_w-1:0] miss_addr;
	logic [word_w-1:0] miss_wdata;
	logic [id_w-1:0] miss_id;
	logic fill_seen;
	logic [addr_w-1:0] fill_line_addr;

	logic [index_w-1:0] rd_index;
	logic rd_valid;
	logic rd_dirty;
	logic [tag_w-1:0] rd_tag;
	logic [line_w-1:0] rd_line;
	logic wr_en;
	logic [index_w-1:0] wr_index;
	logic [tag_w-1:0] wr_tag;
	logic [line_w-1:0] wr_line;
	logic wr_dirty;

	assign reqq_op = req_op_e'(reqq_op_bit);
	assign dram_fill_accept = !dfpq_full;
	assign rsp_valid = !cwbq_empty;
	assign dram_wb_req = !dwbq_empty;

	bank_fifo #(.width(1 + addr_w + word_w + id_w), .depth(reqq_depth)) reqq (
		.clk     (clk),
		.reset   (reset),
		.push    (req_valid),
		.in_data ({req_op, req_addr, req_wdata, req_id}),
		.pop     (reqq_pop),
		.out_data({reqq_op_bit, reqq_addr, reqq_wdata, reqq_id}),
		.empty   (reqq_empty),
		.full    (req_full)
	);

	bank_fifo #(.width(addr_w + line_w), .depth(dfpq_depth)) dfpq (
		.clk     (clk),
		.reset   (reset),
		.push    (dram_fill_rsp),
		.in_data ({dram_fill_addr, dram_fill_data}),
		.pop     (dfpq_pop),
		.out_data({dfpq_addr, dfpq_line}),
		.empty   (dfpq_empty),
		.full    (dfpq_full)
	);

	bank_fifo #(.width(id_w + addr_w + word_w), .depth(cwbq_depth)) cwbq (
		.clk     (clk),
		.reset   (reset),
		.push    (cwbq_push),
		.in_data ({cwbq_id, cwbq_addr, cwbq_data}),
		.pop     (rsp_pop),
		.out_data({rsp_id, rsp_addr, rsp_data}),
		.empty   (cwbq_empty),
		.full    (cwbq_full)
	);

	bank_fifo #(.width(addr_w + line_w), .depth(dwbq_depth)) dwbq (
		.clk     (clk),
		.reset   (reset),
		.push    (dwbq_push),
		.in_data ({dwbq_addr, dwbq_line}),
		.pop     (dram_wb_pop),
		.out_data({dram_wb_addr, dram_wb_data}),
		.empty   (dwbq_empty),
		.full    (dwbq_full)
	);

	miss_reserve mrvq (
		.clk           (clk),
		.reset         (reset),
		.add           (mrvq_add),
		.add_op        (miss_op),
		.add_addr      (miss_addr),
		.add_wdata     (miss_wdata),
		.add_id        (miss_id),
		.fill_seen     (fill_seen),
		.fill_line_addr(fill_line_addr),
		.pop           (mrvq_pop),
		.head_ready    (mrvq_head_ready),
		.head_op       (mrvq_head_op),
		.head_addr     (mrvq_head_addr),
		.head_wdata    (mrvq_head_wdata),
		.head_id       (mrvq_head_id),
		.almost_full   (mrvq_almost_full),
		.full          (mrvq_full)
	);

	// Port names match the local wires one to one
	tag_data_store store (.*);

	bank_pipeline pipe (.*);

endmodule

// File: hw/cache_bank_pkg.sv
package cache_bank_pkg;

	localparam int addr_w = 32;
	localparam int word_w = 32;
	localparam int line_words = 4;
	localparam int num_lines = 64;
	localparam int id_w = 4;

	// Address split is tag | index | word offset | byte
	localparam int byte_w = 2;
	localparam int offset_w = $clog2(line_words);
	localparam int index_w = $clog2(num_lines);
	localparam int tag_w = addr_w - index_w - offset_w - byte_w;
	localparam int line_lsb = byte_w + offset_w;
	localparam int tag_lsb = line_lsb + index_w;
	localparam int line_w = line_words * word_w;

	// Queue sizes
	localparam int reqq_depth = 8;
	localparam int mrvq_depth = 8;
	localparam int mrvq_stop_margin = 2;
	localparam int mrvq_ptr_w = $clog2(mrvq_depth);
	localparam int mrvq_cnt_w = $clog2(mrvq_depth + 1);
	localparam int dfpq_depth = 2;
	localparam int cwbq_depth = 8;
	localparam int dwbq_depth = 4;

	typedef enum logic {
		op_read,
		op_write
	} req_op_e;

	// Which queue fed the item now in a stage
	typedef enum logic [1:0] {
		src_none,
		src_replay,
		src_fill,
		src_core
	} pipe_src_e;

endpackage

// File: hw/miss_reserve.sv
`timescale 1ns/1ps

module miss_reserve (
	input  logic clk,
	input  logic reset,
	input  logic add,
	input  cache_bank_pkg::req_op_e add_op,
	input  logic [cache_bank_pkg::addr_w-1:0] add_addr,
	input  logic [cache_bank_pkg::word_w-1:0] add_wdata,
	input  logic [cache_bank_pkg::id_w-1:0] add_id,
	input  logic fill_seen,
	input  logic [cache_bank_pkg::addr_w-1:0] fill_line_addr,
	input  logic pop,
	output logic head_ready,
	output cache_bank_pkg::req_op_e head_op,
	output logic [cache_bank_pkg::addr_w-1:0] head_addr,
	output logic [cache_bank_pkg::word_w-1:0] head_wdata,
	output logic [cache_bank_pkg::id_w-1:0] head_id,
	output logic almost_full,
	output logic full
);
	import cache_bank_pkg::*;

	req_op_e entry_op [mrvq_depth];
	logic [addr_w-1:0] entry_addr [mrvq_depth];
	logic [word_w-1:0] entry_wdata [mrvq_depth];
	logic [id_w-1:0] entry_id [mrvq_depth];
	logic [mrvq_depth-1:0] entry_ready;
	logic [mrvq_ptr_w-1:0] head_ptr;
	logic [mrvq_ptr_w-1:0] tail_ptr;
	logic [mrvq_cnt_w-1:0] count;
	logic do_add;
	logic do_pop;

	assign do_add = add && !full;
	assign do_pop = pop && head_ready;

	// Only the oldest entry may leave
	assign head_ready = (count != 0) && entry_ready[head_ptr];
	assign head_op = entry_op[head_ptr];
	assign head_addr = entry_addr[head_ptr];
	assign head_wdata = entry_wdata[head_ptr];
	assign head_id = entry_id[head_ptr];

	assign full = count == mrvq_cnt_w'(mrvq_depth);
	assign almost_full = count >= mrvq_cnt_w'(mrvq_depth - mrvq_stop_margin);

	always_ff @(posedge clk) begin
		if (reset) begin
			entry_ready <= '0;
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end else begin
			// Wake every waiter on the filled line
			for (int i = 0; i < mrvq_depth; i++) begin
				if (fill_seen &&
						entry_addr[i][addr_w-1:line_lsb] == fill_line_addr[addr_w-1:line_lsb]) begin
					entry_ready[i] <= 1'b1;
				end
			end
			if (do_pop) begin
				entry_ready[head_ptr] <= 1'b0;
				head_ptr <= head_ptr + 1'b1;
			end
			if (do_add) begin
				entry_ready[tail_ptr] <= 1'b0;
				tail_ptr <= tail_ptr + 1'b1;
			end
			count <= count + mrvq_cnt_w'(do_add) - mrvq_cnt_w'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_add) begin
			entry_op[tail_ptr] <= add_op;
			entry_addr[tail_ptr] <= add_addr;
			entry_wdata[tail_ptr] <= add_wdata;
			entry_id[tail_ptr] <= add_id;
		end
	end

endmodule

// File: hw/tag_data_store.sv
`timescale 1ns/1ps

module tag_data_store (
	input  logic clk,
	input  logic reset,
	input  logic [cache_bank_pkg::index_w-1:0] rd_index,
	output logic rd_valid,
	output logic rd_dirty,
	output logic [cache_bank_pkg::tag_w-1:0] rd_tag,
	output logic [cache_bank_pkg::line_w-1:0] rd_line,
	input  logic wr_en,
	input  logic [cache_bank_pkg::index_w-1:0] wr_index,
	input  logic [cache_bank_pkg::tag_w-1:0] wr_tag,
	input  logic [cache_bank_pkg::line_w-1:0] wr_line,
	input  logic wr_dirty
);
	import cache_bank_pkg::*;

	logic [num_lines-1:0] valid_bits;
	logic [num_lines-1:0] dirty_bits;
	logic [tag_w-1:0] tags [num_lines];
	logic [line_w-1:0] lines [num_lines];

	// Read is asynchronous, the stage 1 register sits in front
	assign rd_valid = valid_bits[rd_index];
	assign rd_dirty = dirty_bits[rd_index];
	assign rd_tag = tags[rd_index];
	assign rd_line = lines[rd_index];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en) begin
			valid_bits[wr_index] <= 1'b1;
			dirty_bits[wr_index] <= wr_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tags[wr_index] <= wr_tag;
			lines[wr_index] <= wr_line;
		end
	end

endmodule

// File: tb.f
hw/cache_bank_pkg.sv
hw/bank_fifo.sv
hw/miss_reserve.sv
hw/tag_data_store.sv
hw/bank_pipeline.sv
hw/cache_bank.sv
verification/cache_bank_tb.sv

// File: verification/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;
	import cache_bank_pkg::*;

	localparam int clk_period = 8;
	localparam int fill_delay = 32;
	localparam int num_ids = 1 << id_w;
	localparam int random_count = 200;
	localparam int total_requests = 1 + 2 + 3 + num_ids + random_count;
	localparam int cycles_per_request = 400;
	localparam logic [31:0] init_pattern = 32'h5a5a_c3c3;

	logic clk;
	logic reset;
	logic req_valid;
	req_op_e req_op;
	logic [addr_w-1:0] req_addr;
	logic [word_w-1:0] req_wdata;
	logic [id_w-1:0] req_id;
	logic req_full;
	logic rsp_valid;
	logic [id_w-1:0] rsp_id;
	logic [addr_w-1:0] rsp_addr;
	logic [word_w-1:0] rsp_data;
	logic rsp_pop;
	logic dram_fill_req;
	logic [addr_w-1:0] dram_fill_req_addr;
	logic dram_fill_req_full;
	logic dram_fill_rsp;
	logic [addr_w-1:0] dram_fill_addr;
	logic [line_w-1:0] dram_fill_data;
	logic dram_fill_accept;
	logic dram_wb_req;
	logic [addr_w-1:0] dram_wb_addr;
	logic [line_w-1:0] dram_wb_data;
	logic dram_wb_pop;

	logic [31:0] lfsr_state;
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] dram_mem [logic [31:0]];
	logic [line_w-1:0] wb_lines [logic [31:0]];
	logic [31:0] fill_addr_q [$];
	int fill_due_q [$];
	logic pending [num_ids];
	logic [31:0] exp_addr [num_ids];
	logic [31:0] exp_data [num_ids];
	logic [id_w-1:0] next_id;
	int outstanding;
	int cycle;
	bit rsp_hold;
	bit rsp_random;
	bit wb_random;
	bit full_seen;

	cache_bank DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] init_word(input logic [31:0] addr);
		return addr ^ init_pattern;
	endfunction

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic lsb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'ha300_0000;
			end
			value = {value[30:0], lsb};
		end
		return value;
	endfunction

	// Expected response word
	function automatic logic [31:0] expected_word(input req_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata);
		if (op == op_write) begin
			return wdata;
		end else if (ref_mem.exists(addr)) begin
			return ref_mem[addr];
		end else begin
			return init_word(addr);
		end
	endfunction

	function automatic logic [31:0] dram_word(input logic [31:0] addr);
		if (dram_mem.exists(addr)) begin
			return dram_mem[addr];
		end else begin
			return init_word(addr);
		end
	endfunction

	function automatic logic [line_w-1:0] dram_line(input logic [31:0] line_addr);
		logic [line_w-1:0] line;
		for (int w = 0; w < line_words; w++) begin
			line[w*word_w +: word_w] = dram_word(line_addr + 32'(4 * w));
		end
		return line;
	endfunction

	function automatic logic line_in_flight(input logic [31:0] addr);
		for (int i = 0; i < num_ids; i++) begin
			if (pending[i] && exp_addr[i][31:line_lsb] == addr[31:line_lsb]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, actual, expected));
		end
	endtask

	// Called 1 ns after a rising edge, returns at the same point of a later cycle
	task automatic issue(input req_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
		logic [id_w-1:0] id;
		id = next_id;
		while (pending[id] || req_full) begin
			@(posedge clk);
			#1;
		end
		exp_addr[id] = addr;
		exp_data[id] = expected_word(op, addr, wdata);
		if (op == op_write) begin
			ref_mem[addr] = wdata;
		end
		pending[id] = 1'b1;
		outstanding = outstanding + 1;
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_wdata = wdata;
		req_id = id;
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		next_id = id + 1'b1;
	endtask

	task automatic wait_idle();
		while (outstanding != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Response checker
	always @(negedge clk) begin
		if (!reset && rsp_pop && rsp_valid) begin
			if (!pending[rsp_id]) begin
				abort_run($sformatf("Response for id %0d, which has no request outstanding",
					rsp_id));
			end else begin
				check_equal("rsp_addr", rsp_addr, exp_addr[rsp_id]);
				check_equal("rsp_data", rsp_data, exp_data[rsp_id]);
				pending[rsp_id] = 1'b0;
				outstanding = outstanding - 1;
			end
		end
		if (req_full === 1'b1) begin
			full_seen = 1'b1;
		end
	end

	always @(posedge clk) begin
		#1;
		if (reset || rsp_hold) begin
			rsp_pop = 1'b0;
		end else if (rsp_random) begin
			rsp_pop = rsp_valid && rand_bits(1) != 0;
		end else begin
			rsp_pop = rsp_valid;
		end
	end

	// DRAM model, capture side
	always @(negedge clk) begin
		if (!reset) begin
			if (dram_fill_req) begin
				fill_addr_q.push_back(dram_fill_req_addr);
				fill_due_q.push_back(cycle + fill_delay);
			end
			if (dram_wb_req && dram_wb_pop) begin
				wb_lines[dram_wb_addr] = dram_wb_data;
				for (int w = 0; w < line_words; w++) begin
					dram_mem[dram_wb_addr + 32'(4 * w)] = dram_wb_data[w*word_w +: word_w];
				end
			end
		end
	end

	// DRAM model, drive side; writebacks drain before a fill is answered
	always @(posedge clk) begin
		cycle = cycle + 1;
		#1;
		dram_fill_rsp = 1'b0;
		if (!reset && fill_addr_q.size() != 0 && cycle >= fill_due_q[0] &&
				dram_fill_accept && !dram_wb_req) begin
			dram_fill_rsp = 1'b1;
			dram_fill_addr = fill_addr_q[0];
			dram_fill_data = dram_line(fill_addr_q[0]);
			void'(fill_addr_q.pop_front());
			void'(fill_due_q.pop_front());
		end
		if (reset || !dram_wb_req) begin
			dram_wb_pop = 1'b0;
		end else if (wb_random) begin
			dram_wb_pop = rand_bits(1) != 0;
		end else begin
			dram_wb_pop = 1'b1;
		end
	end

	initial begin
		repeat (cycles_per_request * total_requests) @(posedge clk);
		abort_run($sformatf("Run timed out after %0d cycles with %0d requests outstanding",
			cycles_per_request * total_requests, outstanding));
	end

	initial begin
		int n;
		req_op_e op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [1:0] tag_sel;
		logic [1:0] index_sel;
		logic [1:0] offset_sel;

		lfsr_state = 32'h98ac20cf;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = op_read;
		req_addr = '0;
		req_wdata = '0;
		req_id = '0;
		rsp_pop = 1'b0;
		dram_fill_req_full = 1'b0;
		dram_fill_rsp = 1'b0;
		dram_fill_addr = '0;
		dram_fill_data = '0;
		dram_wb_pop = 1'b0;
		next_id = '0;
		outstanding = 0;
		cycle = 0;
		rsp_hold = 1'b0;
		rsp_random = 1'b0;
		wb_random = 1'b0;
		full_seen = 1'b0;
		for (int i = 0; i < num_ids; i++) begin
			pending[i] = 1'b0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Quiet outputs before any request
		repeat (6) begin
			@(negedge clk);
			check_equal("rsp_valid", rsp_valid, 0);
			check_equal("dram_fill_req", dram_fill_req, 0);
			check_equal("dram_wb_req", dram_wb_req, 0);
			check_equal("req_full", req_full, 0);
		end
		@(posedge clk);
		#1;

		// Cold miss
		issue(op_read, 32'h0000_1234, 32'h0);
		wait_idle();

		// Write, then read back
		wdata = rand_bits(32);
		issue(op_write, 32'h0000_5678, wdata);
		wait_idle();
		issue(op_read, 32'h0000_5678, 32'h0);
		wait_idle();

		// A and B share index 4 with different tags
		wdata = rand_bits(32);
		issue(op_write, 32'h0000_2048, wdata);
		wait_idle();
		issue(op_read, 32'h0000_3040, 32'h0);
		wait_idle();
		issue(op_read, 32'h0000_2048, 32'h0);
		wait_idle();
		if (!wb_lines.exists(32'h0000_2040)) begin
			abort_run("The dirty line evicted by the conflicting fill never reached DRAM");
		end else begin
			check_equal("dram_wb_data", wb_lines[32'h0000_2040][2*word_w +: word_w], wdata);
		end

		// Held responses back up into the request queue
		rsp_hold = 1'b1;
		full_seen = 1'b0;
		for (int k = 0; k < num_ids; k++) begin
			issue(op_read, 32'h0002_0000 + 32'(16 * k), 32'h0);
		end
		n = 0;
		while (!full_seen && n < 50) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!full_seen) begin
			abort_run("req_full never rose while responses were held back");
		end
		rsp_hold = 1'b0;
		wait_idle();

		// Random mix over 16 lines on 4 indexes
		rsp_random = 1'b1;
		wb_random = 1'b1;
		n = 0;
		while (n < random_count) begin
			op = req_op_e'(rand_bits(1));
			tag_sel = rand_bits(2);
			index_sel = rand_bits(2);
			offset_sel = rand_bits(2);
			addr = ((32'h40 + tag_sel) << tag_lsb) | (32'(index_sel) << line_lsb) |
				(32'(offset_sel) << byte_w);
			wdata = (op == op_write) ? rand_bits(32) : 32'h0;
			// One request per line in flight
			if (line_in_flight(addr)) begin
				@(posedge clk);
				#1;
			end else begin
				issue(op, addr, wdata);
				n++;
			end
		end
		wait_idle();
		rsp_random = 1'b0;
		wb_random = 1'b0;

		@(negedge clk);
		check_equal("rsp_valid", rsp_valid, 0);
		$display("Finished with no errors");
		$finish;
	end

endmodule
